// File: hdl/padding_dma_defs.svh
// Shared sizes for the padding DMA
// Matrix width W must fit PD_DIM_W bits, so W is at most 60 once padded to W+2
`ifndef PADDING_DMA_DEFS_SVH
`define PADDING_DMA_DEFS_SVH

`define PD_DATA_W     32
`define PD_ADDR_W     32
`define PD_DIM_W      6

// Tile and padded window sides, in words
`define PD_TILE       4
`define PD_WIN        6

`define PD_WORD_BYTES 4
`define PD_LEN_W      4   // AXI len field

`endif

// File: hdl/padding_dma_pkg.sv
// Types shared by the padding DMA stages

package padding_dma_pkg;

    // Which matrix borders the current tile touches
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edge_flags_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_PAD,
        SEQ_WRITE
    } seq_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

endpackage

// File: hdl/tile_if.sv
// Tile descriptor plus stage handshakes, and the window write port
// Sequencer holds the descriptor stable while a tile is in flight
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

interface tile_if;
    import padding_dma_pkg::*;

    logic [`PD_ADDR_W-1:0] src_base, dst_base;
    logic [`PD_DIM_W-1:0]  width, tile_x, tile_y;
    edge_flags_t           edges;
    logic fetch_go, pad_go, write_go;
    logic fetch_done, pad_done, write_done;

    modport seq (output src_base, dst_base, width, tile_x, tile_y, edges,
                 output fetch_go, pad_go, write_go,
                 input fetch_done, pad_done, write_done);
    modport reader (input src_base, width, tile_x, tile_y, fetch_go, output fetch_done);
    modport pad (input edges, pad_go, output pad_done);
    modport writer (input dst_base, width, tile_x, tile_y, edges, write_go,
                    output write_done);
endinterface

interface win_wr_if;
    logic                          we;
    logic [$clog2(`PD_WIN)-1:0]    col, row;
    logic [`PD_DATA_W-1:0]         data;

    modport reader (output we, col, row, data);
    modport pad (input we, col, row, data);
endinterface

// File: hdl/tile_sequencer.sv
// Accepts a start only for W a multiple of 4 and at least 8, others are dropped
// Walks tiles in row-major order, one tile through fetch, pad and write at a time
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module tile_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [`PD_ADDR_W-1:0] src_addr_i,
    input  logic [`PD_ADDR_W-1:0] dst_addr_i,
    input  logic [`PD_DIM_W-1:0]  width_i,
    output logic                  done_o,
    tile_if.seq                   t
);
    import padding_dma_pkg::*;

    seq_state_t            state;
    logic [`PD_ADDR_W-1:0] src_q, dst_q;
    logic [`PD_DIM_W-1:0]  width_q, tile_x_q, tile_y_q, last_tile;
    logic                  width_ok, accept, last_x, last_y, finish;
    logic                  fetch_go_q, pad_go_q, write_go_q;

    assign width_ok  = (width_i[1:0] == 2'b00) && (width_i >= `PD_DIM_W'(8));
    assign accept    = (state == SEQ_IDLE) && start_i && width_ok;
    assign last_tile = (width_q >> 2) - `PD_DIM_W'(1);
    assign last_x    = (tile_x_q == last_tile);
    assign last_y    = (tile_y_q == last_tile);
    assign finish    = (state == SEQ_WRITE) && t.write_done && last_x && last_y;
    assign done_o    = (state == SEQ_IDLE) || finish;  // Up with the last write_done

    assign t.src_base = src_q;
    assign t.dst_base = dst_q;
    assign t.width    = width_q;
    assign t.tile_x   = tile_x_q;
    assign t.tile_y   = tile_y_q;
    assign t.edges    = '{top: tile_y_q == '0, bottom: last_y,
                          left: tile_x_q == '0, right: last_x};
    assign t.fetch_go = fetch_go_q;
    assign t.pad_go   = pad_go_q;
    assign t.write_go = write_go_q;

    // Configuration latch
    always_ff @(posedge clk) begin
        if (accept) begin
            src_q   <= src_addr_i;
            dst_q   <= dst_addr_i;
            width_q <= width_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            tile_x_q   <= '0;
            tile_y_q   <= '0;
            fetch_go_q <= 1'b0;
            pad_go_q   <= 1'b0;
            write_go_q <= 1'b0;
        end else begin
            fetch_go_q <= 1'b0;
            pad_go_q   <= 1'b0;
            write_go_q <= 1'b0;
            case (state)
                SEQ_IDLE: if (accept) begin
                    tile_x_q   <= '0;
                    tile_y_q   <= '0;
                    fetch_go_q <= 1'b1;
                    state      <= SEQ_FETCH;
                end
                SEQ_FETCH: if (t.fetch_done) begin
                    pad_go_q <= 1'b1;
                    state    <= SEQ_PAD;
                end
                SEQ_PAD: if (t.pad_done) begin
                    write_go_q <= 1'b1;
                    state      <= SEQ_WRITE;
                end
                SEQ_WRITE: if (t.write_done) begin
                    if (last_x && last_y) begin
                        state <= SEQ_IDLE;
                    end else begin
                        if (last_x) begin  // Wrap to next tile row
                            tile_x_q <= '0;
                            tile_y_q <= tile_y_q + `PD_DIM_W'(1);
                        end else begin
                            tile_x_q <= tile_x_q + `PD_DIM_W'(1);
                        end
                        fetch_go_q <= 1'b1;
                        state      <= SEQ_FETCH;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end
endmodule

// File: hdl/tile_reader.sv
// Fetches one 4x4 tile as four INCR bursts of four full words
// Relies on rlast to end each burst, beats land at window rows and columns 1..4
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module tile_reader (
    input  logic                  clk,
    input  logic                  rst_n,
    tile_if.reader                t,
    win_wr_if.reader              w,
    output logic [`PD_ADDR_W-1:0] araddr_o,
    output logic [`PD_LEN_W-1:0]  arlen_o,
    output logic                  arvalid_o,
    input  logic                  arready_i,
    input  logic [`PD_DATA_W-1:0] rdata_i,
    input  logic                  rlast_i,
    input  logic                  rvalid_i,
    output logic                  rready_o
);
    import padding_dma_pkg::*;

    rd_state_t             state;
    logic [1:0]            row_q, beat_q;
    logic                  done_q;
    logic [`PD_ADDR_W-1:0] src_row, src_col;

    // Source word index of the row start
    assign src_row  = `PD_ADDR_W'(t.tile_y) * `PD_TILE + `PD_ADDR_W'(row_q);
    assign src_col  = `PD_ADDR_W'(t.tile_x) * `PD_TILE;
    assign araddr_o = t.src_base + (src_row * `PD_ADDR_W'(t.width) + src_col) * `PD_WORD_BYTES;
    assign arlen_o  = `PD_LEN_W'(`PD_TILE - 1);

    assign arvalid_o    = (state == RD_ADDR);
    assign rready_o     = (state == RD_DATA);
    assign t.fetch_done = done_q;

    assign w.we   = (state == RD_DATA) && rvalid_i;
    assign w.col  = {1'b0, beat_q} + 3'd1;  // Skip the border column
    assign w.row  = {1'b0, row_q} + 3'd1;
    assign w.data = rdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= RD_IDLE;
            row_q  <= '0;
            beat_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                RD_IDLE: if (t.fetch_go) begin
                    row_q <= '0;
                    state <= RD_ADDR;
                end
                RD_ADDR: if (arready_i) begin
                    beat_q <= '0;
                    state  <= RD_DATA;
                end
                RD_DATA: if (rvalid_i) begin
                    beat_q <= beat_q + 2'd1;
                    if (rlast_i) begin
                        if (row_q == 2'd3) begin
                            done_q <= 1'b1;
                            state  <= RD_IDLE;
                        end else begin
                            row_q <= row_q + 2'd1;
                            state <= RD_ADDR;  // Next row's AR
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end
endmodule

// File: hdl/pad_window.sv
// 6x6 tile window, data at rows and columns 1..4, border filled by reflection
// Row pass one cycle after pad_go, column pass the cycle after that
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module pad_window (
    input  logic                         clk,
    input  logic                         rst_n,
    tile_if.pad                          t,
    win_wr_if.pad                        w,
    input  logic [$clog2(`PD_WIN)-1:0]   rd_col_i,
    input  logic [$clog2(`PD_WIN)-1:0]   rd_row_i,
    output logic [`PD_DATA_W-1:0]        rd_data_o
);
    import padding_dma_pkg::*;

    logic [`PD_DATA_W-1:0] win [0:`PD_WIN-1][0:`PD_WIN-1];  // [row][col]
    logic                  row_pass_q, col_pass_q;
    edge_flags_t           edges_q;

    assign t.pad_done = col_pass_q;
    assign rd_data_o  = win[rd_row_i][rd_col_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_pass_q <= 1'b0;
            col_pass_q <= 1'b0;
        end else begin
            row_pass_q <= t.pad_go;
            col_pass_q <= row_pass_q;
        end
    end

    // Edges captured for both passes
    always_ff @(posedge clk) begin
        if (t.pad_go) edges_q <= t.edges;
    end

    always_ff @(posedge clk) begin
        if (w.we) win[w.row][w.col] <= w.data;
        if (row_pass_q) begin
            for (int c = 0; c < `PD_WIN; c++) begin
                if (edges_q.top)    win[0][c] <= win[2][c];  // Input row 1
                if (edges_q.bottom) win[5][c] <= win[3][c];  // Input row W-2
            end
        end
        // Whole columns, so the corners pick up the row pass result
        if (col_pass_q) begin
            for (int r = 0; r < `PD_WIN; r++) begin
                if (edges_q.left)  win[r][0] <= win[r][2];
                if (edges_q.right) win[r][5] <= win[r][3];
            end
        end
    end
endmodule

// File: hdl/tile_writer.sv
// Writes a tile's padded rows, one INCR burst of 4 to 6 words per window row
// Border rows and columns are written only on tiles at that matrix edge
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module tile_writer (
    input  logic                        clk,
    input  logic                        rst_n,
    tile_if.writer                      t,
    output logic [$clog2(`PD_WIN)-1:0]  rd_col_o,
    output logic [$clog2(`PD_WIN)-1:0]  rd_row_o,
    input  logic [`PD_DATA_W-1:0]       rd_data_i,
    output logic [`PD_ADDR_W-1:0]       awaddr_o,
    output logic [`PD_LEN_W-1:0]        awlen_o,
    output logic                        awvalid_o,
    input  logic                        awready_i,
    output logic [`PD_DATA_W-1:0]       wdata_o,
    output logic                        wlast_o,
    output logic                        wvalid_o,
    input  logic                        wready_i,
    input  logic                        bvalid_i,
    output logic                        bready_o
);
    import padding_dma_pkg::*;

    wr_state_t             state;
    logic [2:0]            row_q, col_q;
    logic [2:0]            col_first, col_last, row_first, row_last;
    logic                  done_q;
    logic [`PD_ADDR_W-1:0] dst_row, dst_col, pitch;

    // Window span for this tile
    assign col_first = t.edges.left   ? 3'd0 : 3'd1;
    assign col_last  = t.edges.right  ? 3'd5 : 3'd4;
    assign row_first = t.edges.top    ? 3'd0 : 3'd1;
    assign row_last  = t.edges.bottom ? 3'd5 : 3'd4;

    // Padded coordinate is tile origin plus window index
    assign dst_row  = `PD_ADDR_W'(t.tile_y) * `PD_TILE + `PD_ADDR_W'(row_q);
    assign dst_col  = `PD_ADDR_W'(t.tile_x) * `PD_TILE + `PD_ADDR_W'(col_first);
    assign pitch    = `PD_ADDR_W'(t.width) + `PD_ADDR_W'(2);
    assign awaddr_o = t.dst_base + (dst_row * pitch + dst_col) * `PD_WORD_BYTES;
    assign awlen_o  = `PD_LEN_W'(col_last - col_first);

    assign rd_col_o     = col_q;
    assign rd_row_o     = row_q;
    assign wdata_o      = rd_data_i;
    assign awvalid_o    = (state == WR_ADDR);
    assign wvalid_o     = (state == WR_DATA);
    assign wlast_o      = (state == WR_DATA) && (col_q == col_last);
    assign bready_o     = (state == WR_RESP);
    assign t.write_done = done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= WR_IDLE;
            row_q  <= '0;
            col_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                WR_IDLE: if (t.write_go) begin
                    row_q <= row_first;
                    col_q <= col_first;
                    state <= WR_ADDR;
                end
                WR_ADDR: if (awready_i) state <= WR_DATA;
                WR_DATA: if (wready_i) begin
                    if (wlast_o) begin
                        col_q <= col_first;
                        state <= WR_RESP;
                    end else begin
                        col_q <= col_q + 3'd1;
                    end
                end
                WR_RESP: if (bvalid_i) begin  // One B per row
                    if (row_q == row_last) begin
                        done_q <= 1'b1;
                        state  <= WR_IDLE;
                    end else begin
                        row_q <= row_q + 3'd1;
                        state <= WR_ADDR;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end
endmodule

// File: hdl/padding_dma_top.sv
// Padding DMA top, AXI channels as plain ports
// Slave side must treat every burst as INCR of full 4-byte words, responses are not checked
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module padding_dma_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [`PD_ADDR_W-1:0] src_addr_i,
    input  logic [`PD_ADDR_W-1:0] dst_addr_i,
    input  logic [`PD_DIM_W-1:0]  width_i,
    output logic                  done_o,
    // AR and R
    output logic [`PD_ADDR_W-1:0] araddr_o,
    output logic [`PD_LEN_W-1:0]  arlen_o,
    output logic                  arvalid_o,
    input  logic                  arready_i,
    input  logic [`PD_DATA_W-1:0] rdata_i,
    input  logic                  rlast_i,
    input  logic                  rvalid_i,
    output logic                  rready_o,
    // AW, W and B
    output logic [`PD_ADDR_W-1:0] awaddr_o,
    output logic [`PD_LEN_W-1:0]  awlen_o,
    output logic                  awvalid_o,
    input  logic                  awready_i,
    output logic [`PD_DATA_W-1:0] wdata_o,
    output logic                  wlast_o,
    output logic                  wvalid_o,
    input  logic                  wready_i,
    input  logic                  bvalid_i,
    output logic                  bready_o
);
    tile_if   tile_bus ();
    win_wr_if win_bus ();

    logic [$clog2(`PD_WIN)-1:0] rd_col, rd_row;  // Writer read port into window
    logic [`PD_DATA_W-1:0]      rd_data;

    tile_sequencer u_seq (.clk, .rst_n, .start_i, .src_addr_i, .dst_addr_i, .width_i,
                          .done_o, .t(tile_bus));

    tile_reader u_rd (.clk, .rst_n, .t(tile_bus), .w(win_bus), .araddr_o, .arlen_o,
                      .arvalid_o, .arready_i, .rdata_i, .rlast_i, .rvalid_i, .rready_o);

    pad_window u_win (.clk, .rst_n, .t(tile_bus), .w(win_bus), .rd_col_i(rd_col),
                      .rd_row_i(rd_row), .rd_data_o(rd_data));

    tile_writer u_wr (.clk, .rst_n, .t(tile_bus), .rd_col_o(rd_col), .rd_row_o(rd_row),
                      .rd_data_i(rd_data), .awaddr_o, .awlen_o, .awvalid_o, .awready_i,
                      .wdata_o, .wlast_o, .wvalid_o, .wready_i, .bvalid_i, .bready_o);
endmodule

// File: tb/tb_clkgen.sv
// Free-running 4 ns clock
// rst_n is held low for RESET_CYCLES rising edges and then released on an edge
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end
endmodule

// File: tb/padding_dma_checker.sv
// Scoreboard for the padded copy, checks every W beat against a reflection model
// Destination words are counted one by one, so both regions must fit in MEM_WORDS
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module padding_dma_checker #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [`PD_ADDR_W-1:0] src_addr_i,
    input  logic [`PD_ADDR_W-1:0] dst_addr_i,
    input  logic [`PD_DIM_W-1:0]  width_i,
    input  logic                  done_i,
    input  logic                  arvalid_i,
    input  logic                  arready_i,
    input  logic [`PD_LEN_W-1:0]  arlen_i,
    input  logic                  awvalid_i,
    input  logic                  awready_i,
    input  logic [`PD_ADDR_W-1:0] awaddr_i,
    input  logic [`PD_LEN_W-1:0]  awlen_i,
    input  logic                  wvalid_i,
    input  logic                  wready_i,
    input  logic [`PD_DATA_W-1:0] wdata_i,
    input  logic                  wlast_i,
    input  logic                  bvalid_i,
    input  logic                  bready_i,
    input  logic [`PD_DATA_W-1:0] mem_i [0:MEM_WORDS-1],
    output int                    errors_o
);
    logic [`PD_ADDR_W-1:0] src_q, dst_q, cur_addr;
    int                    w_q, beat, len_q, aw_count, b_count;
    int                    err_count     = 0;
    logic                  active        = 1'b0;
    logic                  reset_checked = 1'b0;
    int                    write_count [0:MEM_WORDS-1];

    assign errors_o = err_count;

    // Padded coordinate back to an input coordinate
    function automatic int reflect_index(input int p, input int w);
        if (p == 0) return 1;
        if (p == w + 1) return w - 2;
        return p - 1;
    endfunction

    function automatic logic in_region(input logic [`PD_ADDR_W-1:0] addr);
        int idx;
        idx = int'((addr - dst_q) >> 2);
        return (addr >= dst_q) && (addr[1:0] == 2'b00) && (idx < (w_q + 2) * (w_q + 2));
    endfunction

    // Destination address to padded cell (r, c), then to the source word
    function automatic logic [`PD_DATA_W-1:0] expected_word(input logic [`PD_ADDR_W-1:0] addr);
        int idx, r, c;
        idx = int'((addr - dst_q) >> 2);
        r   = idx / (w_q + 2);
        c   = idx % (w_q + 2);
        return mem_i[int'(src_q >> 2) + reflect_index(r, w_q) * w_q + reflect_index(c, w_q)];
    endfunction

    always @(posedge clk) begin
        logic [`PD_DATA_W-1:0] exp_word;
        int                    span;
        if (rst_n) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!done_i || arvalid_i || awvalid_i || wvalid_i) begin
                    $display("ERROR after reset done_o=%h arvalid_o=%h awvalid_o=%h wvalid_o=%h",
                             done_i, arvalid_i, awvalid_i, wvalid_i);
                    err_count++;
                end
            end
            if (!active) begin
                if (arvalid_i || awvalid_i) begin
                    $display("Bus request seen while no run was accepted");
                    err_count++;
                end
                if (!done_i) begin
                    $display("done_o is low while no run was accepted");
                    err_count++;
                end
                // Only widths that are a multiple of 4 and at least 8 start a run
                if (start_i && width_i[1:0] == 2'b00 && width_i >= 6'd8) begin
                    src_q    = src_addr_i;
                    dst_q    = dst_addr_i;
                    w_q      = int'(width_i);
                    aw_count = 0;
                    b_count  = 0;
                    for (int i = 0; i < MEM_WORDS; i++) write_count[i] = 0;
                    active   = 1'b1;
                end
            end else begin
                if (arvalid_i && arready_i && arlen_i != 4'h3) begin
                    $display("ERROR arlen_o=%h expected=%h", arlen_i, 4'h3);
                    err_count++;
                end
                if (awvalid_i && awready_i) begin
                    if (awlen_i < 4'h3 || awlen_i > 4'h5) begin
                        $display("ERROR awlen_o=%h expected 3, 4 or 5", awlen_i);
                        err_count++;
                    end
                    cur_addr = awaddr_i;
                    len_q    = int'(awlen_i);
                    beat     = 0;
                    aw_count++;
                end
                if (wvalid_i && wready_i) begin
                    if (!in_region(cur_addr)) begin
                        $display("Write to address %h lies outside the destination", cur_addr);
                        err_count++;
                    end else begin
                        exp_word = expected_word(cur_addr);
                        if (wdata_i !== exp_word) begin
                            $display("ERROR wdata_o=%h expected=%h addr=%h",
                                     wdata_i, exp_word, cur_addr);
                            err_count++;
                        end
                        write_count[int'(cur_addr >> 2)]++;
                    end
                    if (wlast_i !== (beat == len_q)) begin
                        $display("ERROR wlast_o=%h expected=%h addr=%h",
                                 wlast_i, (beat == len_q), cur_addr);
                        err_count++;
                    end
                    cur_addr = cur_addr + 32'd4;
                    beat++;
                end
                if (bvalid_i && bready_i) b_count++;
                // End of run, every padded word exactly once
                if (done_i) begin
                    if (b_count != aw_count) begin
                        $display("done_o rose with %0d of %0d write responses received",
                                 b_count, aw_count);
                        err_count++;
                    end
                    span = (w_q + 2) * (w_q + 2);
                    for (int i = 0; i < span; i++) begin
                        if (write_count[int'(dst_q >> 2) + i] != 1) begin
                            $display("Destination word %0d of width %0d written %0d times",
                                     i, w_q, write_count[int'(dst_q >> 2) + i]);
                            err_count++;
                        end
                    end
                    active = 1'b0;
                end
            end
        end
    end
endmodule

// File: tb/padding_dma_assert.sv
// AXI master checks, bound into the DMA top level
// A beat counter per write burst gives the expected wlast position
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module padding_dma_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`PD_ADDR_W-1:0] araddr_i,
    input logic [`PD_LEN_W-1:0]  arlen_i,
    input logic                  arvalid_i,
    input logic                  arready_i,
    input logic [`PD_ADDR_W-1:0] awaddr_i,
    input logic [`PD_LEN_W-1:0]  awlen_i,
    input logic                  awvalid_i,
    input logic                  awready_i,
    input logic [`PD_DATA_W-1:0] wdata_i,
    input logic                  wlast_i,
    input logic                  wvalid_i,
    input logic                  wready_i
);
    logic [`PD_LEN_W-1:0] beat_q, len_q;
    int                   fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_q <= '0;
            len_q  <= '0;
        end else if (awvalid_i && awready_i) begin
            len_q  <= awlen_i;
            beat_q <= '0;
        end else if (wvalid_i && wready_i) begin
            beat_q <= beat_q + 4'd1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arlen_i))
        else begin
            fail_count++;
            $error("AR request changed or dropped before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
        else begin
            fail_count++;
            $error("AW request changed or dropped before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
        else begin
            fail_count++;
            $error("W beat changed or dropped before wready");
        end

    wlast_place: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i |-> (wlast_i == (beat_q == len_q)))
        else begin
            fail_count++;
            $error("wlast does not match the burst length");
        end
endmodule

// File: tb/tb_padding_dma.sv
// Testbench for the padding DMA, one word memory answers both AXI sides
// Source and destination regions are fixed, W up to 16 fits in MEM_WORDS
`timescale 1ns/1ps
`include "padding_dma_defs.svh"

module tb_padding_dma;
    localparam int MEM_WORDS    = 4096;
    localparam int RESET_CYCLES = 8;
    localparam int SRC_WORD     = 64;    // Byte address 0x100
    localparam int DST_WORD     = 2048;  // Byte address 0x2000
    localparam int N_RUNS       = 5;

    logic                  clk, rst_n;
    logic                  start_i    = 1'b0;
    logic [`PD_ADDR_W-1:0] src_addr_i = '0;
    logic [`PD_ADDR_W-1:0] dst_addr_i = '0;
    logic [`PD_DIM_W-1:0]  width_i    = '0;
    logic                  done_o;
    logic [`PD_ADDR_W-1:0] araddr_o, awaddr_o;
    logic [`PD_LEN_W-1:0]  arlen_o, awlen_o;
    logic                  arvalid_o, rready_o, awvalid_o, wvalid_o, wlast_o, bready_o;
    logic [`PD_DATA_W-1:0] wdata_o;
    logic                  arready_i  = 1'b0;
    logic                  rvalid_i   = 1'b0;
    logic                  rlast_i    = 1'b0;
    logic [`PD_DATA_W-1:0] rdata_i    = '0;
    logic                  awready_i  = 1'b0;
    logic                  wready_i   = 1'b0;
    logic                  bvalid_i   = 1'b0;

    logic [`PD_DATA_W-1:0] mem [0:MEM_WORDS-1];
    integer                seed     = 32'hb017;
    logic                  fill_req = 1'b0;
    int                    fill_len = 0;
    logic [4:0]            rd_left  = '0;  // R beats still owed
    logic [`PD_ADDR_W-1:0] rd_addr  = '0;
    logic [`PD_ADDR_W-1:0] wr_addr  = '0;
    logic                  b_pend   = 1'b0;
    int                    chk_errors, total_errors;
    int                    run_w [N_RUNS] = '{8, 12, 16, 6, 10};  // Last two are ignored

    tb_clkgen #(.RESET_CYCLES(RESET_CYCLES)) u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    padding_dma_top DUT (.*);

    padding_dma_checker #(.MEM_WORDS(MEM_WORDS)) u_checker (
        .clk, .rst_n, .start_i, .src_addr_i, .dst_addr_i, .width_i,
        .done_i(done_o), .arvalid_i(arvalid_o), .arready_i, .arlen_i(arlen_o),
        .awvalid_i(awvalid_o), .awready_i, .awaddr_i(awaddr_o), .awlen_i(awlen_o),
        .wvalid_i(wvalid_o), .wready_i, .wdata_i(wdata_o), .wlast_i(wlast_o),
        .bvalid_i, .bready_i(bready_o), .mem_i(mem), .errors_o(chk_errors)
    );

    bind padding_dma_top padding_dma_assert u_assert (
        .clk, .rst_n, .araddr_i(araddr_o), .arlen_i(arlen_o), .arvalid_i(arvalid_o),
        .arready_i, .awaddr_i(awaddr_o), .awlen_i(awlen_o), .awvalid_i(awvalid_o),
        .awready_i, .wdata_i(wdata_o), .wlast_i(wlast_o), .wvalid_i(wvalid_o), .wready_i
    );

    function automatic logic random_ready();
        return ($random(seed) & 3) != 0;  // High three cycles in four
    endfunction

    // AXI slave memory with random ready and valid delays
    always @(posedge clk) begin
        logic [4:0]            left;
        logic [`PD_ADDR_W-1:0] raddr;
        logic                  resp;
        if (!rst_n) begin
            arready_i <= 1'b0;
            rvalid_i  <= 1'b0;
            rlast_i   <= 1'b0;
            awready_i <= 1'b0;
            wready_i  <= 1'b0;
            bvalid_i  <= 1'b0;
            rd_left   <= '0;
            b_pend    <= 1'b0;
        end else begin
            left  = rd_left;
            raddr = rd_addr;
            if (rvalid_i && rready_o) begin
                left  = left - 5'd1;
                raddr = raddr + 32'd4;
            end
            if (arvalid_o && arready_i) begin
                left  = {1'b0, arlen_o} + 5'd1;
                raddr = araddr_o;
            end
            rd_left   <= left;
            rd_addr   <= raddr;
            arready_i <= random_ready();
            rvalid_i  <= (left != 5'd0) && ((rvalid_i && !rready_o) || random_ready());
            rlast_i   <= (left == 5'd1);
            rdata_i   <= mem[raddr[13:2]];

            // One B per burst, after its last W beat
            resp = b_pend;
            if (awvalid_o && awready_i) wr_addr <= awaddr_o;
            if (wvalid_o && wready_i) begin
                mem[wr_addr[13:2]] <= wdata_o;
                wr_addr <= wr_addr + 32'd4;
                if (wlast_o) resp = 1'b1;
            end
            if (bvalid_i && bready_o) resp = 1'b0;
            b_pend    <= resp;
            bvalid_i  <= resp && ((bvalid_i && !bready_o) || random_ready());
            awready_i <= random_ready();
            wready_i  <= random_ready();
            if (fill_req) begin
                for (int i = 0; i < fill_len; i++) mem[SRC_WORD + i] <= $random(seed);
            end
        end
    end

    task automatic run_matrix(input int w);
        @(posedge clk);
        fill_len <= w * w;
        fill_req <= 1'b1;
        @(posedge clk);
        fill_req   <= 1'b0;
        src_addr_i <= 32'(SRC_WORD * 4);
        dst_addr_i <= 32'(DST_WORD * 4);
        width_i    <= `PD_DIM_W'(w);
        start_i    <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        if (w % 4 == 0 && w >= 8) begin
            do begin
                @(posedge clk);
            end while (!done_o);
        end else begin
            repeat (16) @(posedge clk);  // Ignored start, bus must stay quiet
        end
    endtask

    initial begin
        wait (rst_n === 1'b1);
        for (int i = 0; i < N_RUNS; i++) begin
            run_matrix(run_w[i]);
        end
        repeat (4) @(posedge clk);
        total_errors = chk_errors + DUT.u_assert.fail_count;
        $display("Errors: %0d from checks, %0d from assertions",
                 chk_errors, DUT.u_assert.fail_count);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, 20 cycles per padded word of each run plus reset
    initial begin
        int limit;
        limit = RESET_CYCLES;
        for (int i = 0; i < N_RUNS; i++) limit += 20 * (run_w[i] + 2) * (run_w[i] + 2);
        repeat (limit) @(posedge clk);
        $display("Timeout, the runs did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end
endmodule

// File: src.f
+incdir+hdl
hdl/padding_dma_pkg.sv
hdl/tile_if.sv
hdl/tile_sequencer.sv
hdl/tile_reader.sv
hdl/pad_window.sv
hdl/tile_writer.sv
hdl/padding_dma_top.sv
tb/tb_clkgen.sv
tb/padding_dma_checker.sv
tb/padding_dma_assert.sv
tb/tb_padding_dma.sv

// File: Makefile
# Verilator build and run of the padding DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_padding_dma
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
